//--- list.f
+incdir+include
hdl/bus_pkg.sv
hdl/bus_addr_decode.sv
hdl/block_ram.sv
hdl/board_io.sv
hdl/bus_return.sv
hdl/busmaster.sv
tb/tb_busmaster.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_busmaster
FILELIST  ?= list.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- include/tb_bus_tasks.svh
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_data(input string what, input bus_pkg::bus_data_t got,
			input bus_pkg::bus_data_t exp);
		if (got !== exp)
		begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
			fail_run();
		end
	endtask

	task automatic check_led(input bus_pkg::led_t got, input bus_pkg::led_t exp);
		if (got !== exp)
		begin
			$display("ERROR at %0t: o_led is %h, expected %h", $time, got, exp);
			fail_run();
		end
	endtask

	// Full bus address, as read back from the error register
	task automatic check_addr(input bus_pkg::bus_addr_t got, input bus_pkg::bus_addr_t exp);
		if (got !== exp)
		begin
			$display("ERROR at %0t: error address is %h, expected %h", $time, got, exp);
			fail_run();
		end
	endtask

	// External RAM word address at the chip boundary
	task automatic check_ram_addr(input bus_pkg::ram_addr_t got, input bus_pkg::ram_addr_t exp);
		if (got !== exp)
		begin
			$display("ERROR at %0t: o_ram_addr is %h, expected %h", $time, got, exp);
			fail_run();
		end
	endtask

	task automatic check_err(input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("ERROR at %0t: o_wb_err is %b, expected %b", $time, got, exp);
			fail_run();
		end
	endtask

	// Other single-bit outputs
	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
			fail_run();
		end
	endtask

	task automatic check_latency(input int got, input int exp);
		if (got != exp)
		begin
			$display("ERROR at %0t: response after %0d cycles, expected %0d", $time, got, exp);
			fail_run();
		end
	endtask

	// RAM pass-through, valid while the strobe is held
	task automatic check_ram_outputs(input step_t s);
		check_flag("o_ram_cyc", o_ram_cyc, 1'b1);
		check_flag("o_ram_stb", o_ram_stb, 1'b1);
		check_flag("o_ram_we", o_ram_we, s.we);
		check_ram_addr(o_ram_addr, bus_pkg::ram_addr_t'(s.addr));
		check_data("o_ram_wdata", o_ram_wdata, s.wdata);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Bus transactions
	////////////////////////////////////////////////////////////////////////////

	task automatic start_request(input logic we, input bus_pkg::bus_addr_t addr,
			input bus_pkg::bus_data_t data);
		@(posedge i_clk);
		i_wb_cyc  <= 1'b1;
		i_wb_stb  <= 1'b1;
		i_wb_we   <= we;
		i_wb_addr <= addr;
		i_wb_data <= data;
	endtask

	// Hold the strobe through any stall, drop it on the accepting edge
	task automatic wait_accept();
		int n;
		n = 0;
		@(negedge i_clk);
		while (o_wb_stall)
		begin
			n++;
			if (n > TIMEOUT)
				report_timeout("release of o_wb_stall");
			@(negedge i_clk);
		end
		@(posedge i_clk);
		i_wb_stb <= 1'b0;
	endtask

	// Counts falling edges until ack or err shows up
	task automatic wait_response(output int cycles);
		cycles = 0;
		do
		begin
			@(negedge i_clk);
			cycles++;
			if (cycles > TIMEOUT)
				report_timeout("o_wb_ack or o_wb_err");
		end while (!o_wb_ack && !o_wb_err);
	endtask

	task automatic end_cycle();
		@(posedge i_clk);
		i_wb_cyc  <= 1'b0;
		i_wb_we   <= 1'b0;
		i_ram_err <= 1'b0;
	endtask

`endif

//--- tb/tb_busmaster.sv
module tb_busmaster;

	// Step kinds
	localparam int K_BUS   = 0;
	localparam int K_RAM   = 1;
	localparam int K_MULTI = 2;
	// Cycles any single wait may take
	localparam int TIMEOUT = 40;

	typedef struct {
		int                 kind;
		logic               we;
		bus_pkg::bus_addr_t addr;
		bus_pkg::bus_data_t wdata;
		// Read data, or the word the external RAM returns
		bus_pkg::bus_data_t exp_data;
		logic               exp_err;
		// External RAM stall cycles
		int                 delay;
		// Cycles from strobe edge (or RAM response) to ack/err
		int                 lat;
	} step_t;

	logic               i_clk;
	logic               i_reset;
	logic               i_wb_cyc;
	logic               i_wb_stb;
	logic               i_wb_we;
	bus_pkg::bus_addr_t i_wb_addr;
	bus_pkg::bus_data_t i_wb_data;
	logic               o_wb_ack;
	logic               o_wb_stall;
	logic               o_wb_err;
	bus_pkg::bus_data_t o_wb_idata;
	bus_pkg::sw_t       i_sw;
	bus_pkg::sw_t       i_btn;
	bus_pkg::led_t      o_led;
	logic               o_ram_cyc;
	logic               o_ram_stb;
	logic               o_ram_we;
	bus_pkg::ram_addr_t o_ram_addr;
	bus_pkg::bus_data_t o_ram_wdata;
	logic               i_ram_ack;
	logic               i_ram_stall;
	bus_pkg::bus_data_t i_ram_rdata;
	logic               i_ram_err;

	logic [31:0]        lfsr;
	bus_pkg::sw_t       sw_val;
	bus_pkg::sw_t       btn_val;
	step_t              steps[$];

	busmaster u_busmaster (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_wb_cyc    (i_wb_cyc),
		.i_wb_stb    (i_wb_stb),
		.i_wb_we     (i_wb_we),
		.i_wb_addr   (i_wb_addr),
		.i_wb_data   (i_wb_data),
		.o_wb_ack    (o_wb_ack),
		.o_wb_stall  (o_wb_stall),
		.o_wb_err    (o_wb_err),
		.o_wb_idata  (o_wb_idata),
		.i_sw        (i_sw),
		.i_btn       (i_btn),
		.o_led       (o_led),
		.o_ram_cyc   (o_ram_cyc),
		.o_ram_stb   (o_ram_stb),
		.o_ram_we    (o_ram_we),
		.o_ram_addr  (o_ram_addr),
		.o_ram_wdata (o_ram_wdata),
		.i_ram_ack   (i_ram_ack),
		.i_ram_stall (i_ram_stall),
		.i_ram_rdata (i_ram_rdata),
		.i_ram_err   (i_ram_err)
	);

	// 20 unit period
	initial
	begin
		i_clk = 1'b0;
		forever
			#10 i_clk = ~i_clk;
	end

	task automatic fail_run();
		$display("test failed");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: no %s within %0d cycles", what, TIMEOUT);
		fail_run();
	endtask

`include "tb_bus_tasks.svh"

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	// Galois LFSR over x^32+x^22+x^2+x+1
	// One step per bit taken
	function automatic logic [31:0] rand_bits(input int nbits);
		logic [31:0] val;
		int          i;
		val = '0;
		for (i = 0; i < nbits; i++)
		begin
			val  = {val[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return val;
	endfunction

	// I/O block base plus register index
	function automatic bus_pkg::bus_addr_t io_addr(input bus_pkg::io_addr_t idx);
		return bus_pkg::bus_addr_t'(1 << bus_pkg::IO_SEL_BIT) | bus_pkg::bus_addr_t'(idx);
	endfunction

	task automatic add_step(input int kind, input logic we, input bus_pkg::bus_addr_t addr,
			input bus_pkg::bus_data_t wdata, input bus_pkg::bus_data_t exp_data,
			input logic exp_err, input int delay, input int lat);
		step_t s;
		s = '{kind, we, addr, wdata, exp_data, exp_err, delay, lat};
		steps.push_back(s);
	endtask

	task automatic build_table();
		bus_pkg::bus_addr_t a;
		bus_pkg::bus_data_t d;
		bus_pkg::bus_addr_t bad [5];
		bus_pkg::bus_addr_t mem_a [6];
		bus_pkg::bus_data_t mem_d [6];
		int                 i;
		// Holes, stray I/O bits, high bits, bit above the RAM region
		bad = '{32'h0000_0010, 32'h0000_0108, 32'h8000_0100, 32'h0C00_0000, 32'h0001_8000};
		// Block RAM writes to six distinct words in 2 cycles each
		// Low address bits come from the loop index
		for (i = 0; i < 6; i++)
		begin
			mem_a[i] = bus_pkg::bus_addr_t'(1 << bus_pkg::MEM_SEL_BIT)
				| (rand_bits(bus_pkg::MEM_AW - 3) << 3) | bus_pkg::bus_addr_t'(i);
			mem_d[i] = rand_bits(bus_pkg::DATA_W);
			add_step(K_BUS, 1'b1, mem_a[i], mem_d[i], '0, 1'b0, 0, 2);
		end
		// All six words read back after the last write
		for (i = 0; i < 6; i++)
			add_step(K_BUS, 1'b0, mem_a[i], '0, mem_d[i], 1'b0, 0, 2);
		// Board I/O through the slow group in 3 cycles
		// LED bit 0 always set so the write shows against the reset value
		d = rand_bits(bus_pkg::DATA_W) | 32'h1;
		add_step(K_BUS, 1'b1, io_addr(bus_pkg::IO_REG_LED), d, '0, 1'b0, 0, 3);
		add_step(K_BUS, 1'b0, io_addr(bus_pkg::IO_REG_LED), '0,
			bus_pkg::bus_data_t'(d[bus_pkg::LED_W-1:0]), 1'b0, 0, 3);
		add_step(K_BUS, 1'b0, io_addr(bus_pkg::IO_REG_INPUTS), '0,
			bus_pkg::bus_data_t'({btn_val, sw_val}), 1'b0, 0, 3);
		add_step(K_BUS, 1'b0, io_addr(3'd5), '0, '0, 1'b0, 0, 3);
		// Decode errors each followed by an error address readback
		for (i = 0; i < 5; i++)
		begin
			add_step(K_BUS, i[0], bad[i], '0, '0, 1'b1, 0, 1);
			add_step(K_BUS, 1'b0, io_addr(bus_pkg::IO_REG_ERR_ADDR), '0, bad[i], 1'b0, 0, 3);
		end
		// External RAM write and read followed by a RAM error
		a = bus_pkg::bus_addr_t'(1 << bus_pkg::RAM_SEL_BIT) | rand_bits(bus_pkg::RAM_AW);
		add_step(K_RAM, 1'b1, a, rand_bits(bus_pkg::DATA_W), '0, 1'b0, 3, 1);
		add_step(K_RAM, 1'b0, a, '0, rand_bits(bus_pkg::DATA_W), 1'b0, 1, 1);
		a = bus_pkg::bus_addr_t'(1 << bus_pkg::RAM_SEL_BIT) | rand_bits(bus_pkg::RAM_AW);
		add_step(K_RAM, 1'b0, a, '0, '0, 1'b1, 2, 1);
		add_step(K_BUS, 1'b0, io_addr(bus_pkg::IO_REG_ERR_ADDR), '0, a, 1'b0, 0, 3);
		// RAM ack on top of a block RAM ack
		a = bus_pkg::bus_addr_t'(1 << bus_pkg::MEM_SEL_BIT) | rand_bits(bus_pkg::MEM_AW);
		add_step(K_MULTI, 1'b0, a, '0, '0, 1'b1, 0, 1);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Step execution
	////////////////////////////////////////////////////////////////////////////

	task automatic ram_access(input step_t s);
		int cycles;
		int n;
		start_request(s.we, s.addr, s.wdata);
		i_ram_stall <= (s.delay > 0);
		// Strobe held through the stall and dropped on the accepting edge
		for (n = 0; n <= s.delay; n++)
		begin
			@(negedge i_clk);
			check_ram_outputs(s);
			check_flag("o_wb_stall", o_wb_stall, n < s.delay);
			@(posedge i_clk);
			if (n == s.delay)
				i_wb_stb <= 1'b0;
			else if (n == s.delay - 1)
				i_ram_stall <= 1'b0;
		end
		// Error held until the cycle ends
		// Ack as a single pulse
		if (s.exp_err)
			i_ram_err <= 1'b1;
		else
		begin
			i_ram_ack   <= 1'b1;
			i_ram_rdata <= s.exp_data;
			@(posedge i_clk);
			i_ram_ack   <= 1'b0;
		end
		wait_response(cycles);
		check_latency(cycles, s.lat);
		check_err(o_wb_err, s.exp_err);
		check_flag("o_wb_ack", o_wb_ack, !s.exp_err);
		check_flag("o_ram_stb", o_ram_stb, 1'b0);
		if (!s.we && !s.exp_err)
			check_data("o_wb_idata", o_wb_idata, s.exp_data);
		end_cycle();
	endtask

	task automatic apply_step(input step_t s);
		int cycles;
		int n;
		start_request(s.we, s.addr, s.wdata);
		wait_accept();
		// Second ack lands with the block RAM ack
		if (s.kind == K_MULTI)
		begin
			i_ram_ack   <= 1'b1;
			i_ram_rdata <= rand_bits(bus_pkg::DATA_W);
			@(posedge i_clk);
			i_ram_ack   <= 1'b0;
		end
		wait_response(cycles);
		check_latency(cycles, s.lat);
		check_err(o_wb_err, s.exp_err);
		if (s.kind != K_MULTI)
			check_flag("o_wb_ack", o_wb_ack, !s.exp_err);
		if (!s.we && !s.exp_err && s.addr == io_addr(bus_pkg::IO_REG_ERR_ADDR))
			check_addr(o_wb_idata, s.exp_data);
		else if (!s.we && !s.exp_err)
			check_data("o_wb_idata", o_wb_idata, s.exp_data);
		if (s.we && s.addr == io_addr(bus_pkg::IO_REG_LED))
			check_led(o_led, s.wdata[bus_pkg::LED_W-1:0]);
		// Decode error is a one-cycle pulse with no ack behind it
		if (s.exp_err && s.kind != K_MULTI)
		begin
			for (n = 0; n < 3; n++)
			begin
				@(negedge i_clk);
				check_flag("o_wb_ack after error", o_wb_ack, 1'b0);
				check_err(o_wb_err, 1'b0);
			end
		end
		end_cycle();
	endtask

	initial
	begin
		lfsr        = 32'haba0_60f1;
		sw_val      = bus_pkg::sw_t'(rand_bits(bus_pkg::SW_W));
		btn_val     = bus_pkg::sw_t'(rand_bits(bus_pkg::SW_W));
		i_reset     <= 1'b1;
		i_wb_cyc    <= 1'b0;
		i_wb_stb    <= 1'b0;
		i_wb_we     <= 1'b0;
		i_wb_addr   <= '0;
		i_wb_data   <= '0;
		i_sw        <= sw_val;
		i_btn       <= btn_val;
		i_ram_ack   <= 1'b0;
		i_ram_stall <= 1'b0;
		i_ram_rdata <= '0;
		i_ram_err   <= 1'b0;
		build_table();
		repeat (10) @(posedge i_clk);
		i_reset <= 1'b0;
		foreach (steps[k])
		begin
			if (steps[k].kind == K_RAM)
				ram_access(steps[k]);
			else
				apply_step(steps[k]);
		end
		repeat (2) @(posedge i_clk);
		$display("test passed");
		$finish;
	end

endmodule

//--- hdl/busmaster.sv
module busmaster (
	input  logic                i_clk,
	input  logic                i_reset,
	// Master bus
	input  logic                i_wb_cyc,
	input  logic                i_wb_stb,
	input  logic                i_wb_we,
	input  bus_pkg::bus_addr_t  i_wb_addr,
	input  bus_pkg::bus_data_t  i_wb_data,
	output logic                o_wb_ack,
	output logic                o_wb_stall,
	output logic                o_wb_err,
	output bus_pkg::bus_data_t  o_wb_idata,
	// Board pins
	input  bus_pkg::sw_t        i_sw,
	input  bus_pkg::sw_t        i_btn,
	output bus_pkg::led_t       o_led,
	// External RAM
	output logic                o_ram_cyc,
	output logic                o_ram_stb,
	output logic                o_ram_we,
	output bus_pkg::ram_addr_t  o_ram_addr,
	output bus_pkg::bus_data_t  o_ram_wdata,
	input  logic                i_ram_ack,
	input  logic                i_ram_stall,
	input  bus_pkg::bus_data_t  i_ram_rdata,
	input  logic                i_ram_err
);

	// Decode outputs
	logic               ram_sel;
	logic               mem_stb;
	logic               io_stb;
	logic               decode_err;
	bus_pkg::bus_addr_t sel_addr;

	// Slave returns
	logic               mem_ack;
	bus_pkg::bus_data_t mem_data;
	logic               io_ack;
	bus_pkg::bus_data_t io_data;

	// Captured failing address, read back through board_io
	bus_pkg::bus_addr_t err_addr;

	////////////////////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////////////////////

	bus_addr_decode u_decode (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_wb_stb     (i_wb_stb),
		.i_wb_addr    (i_wb_addr),
		.o_ram_sel    (ram_sel),
		.o_ram_stb    (o_ram_stb),
		.o_mem_stb    (mem_stb),
		.o_io_stb     (io_stb),
		.o_decode_err (decode_err),
		.o_sel_addr   (sel_addr)
	);

	////////////////////////////////////////////////////////////////////////////
	// Slaves
	////////////////////////////////////////////////////////////////////////////

	block_ram u_block_ram (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_stb   (mem_stb),
		.i_we    (i_wb_we),
		.i_addr  (i_wb_addr),
		.i_data  (i_wb_data),
		.o_ack   (mem_ack),
		.o_data  (mem_data)
	);

	board_io u_board_io (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_stb      (io_stb),
		.i_we       (i_wb_we),
		.i_addr     (i_wb_addr),
		.i_data     (i_wb_data),
		.i_sw       (i_sw),
		.i_btn      (i_btn),
		.i_err_addr (err_addr),
		.o_ack      (io_ack),
		.o_data     (io_data),
		.o_led      (o_led)
	);

	// External RAM, pass-through except for the gated strobe
	assign o_ram_cyc   = i_wb_cyc;
	assign o_ram_we    = i_wb_we;
	assign o_ram_addr  = i_wb_addr[bus_pkg::RAM_AW-1:0];
	assign o_ram_wdata = i_wb_data;

	////////////////////////////////////////////////////////////////////////////
	// Return path
	////////////////////////////////////////////////////////////////////////////

	bus_return u_return (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_wb_cyc     (i_wb_cyc),
		.i_ram_sel    (ram_sel),
		.i_mem_ack    (mem_ack),
		.i_mem_data   (mem_data),
		.i_io_ack     (io_ack),
		.i_io_data    (io_data),
		.i_ram_ack    (i_ram_ack),
		.i_ram_stall  (i_ram_stall),
		.i_ram_rdata  (i_ram_rdata),
		.i_ram_err    (i_ram_err),
		.i_decode_err (decode_err),
		.i_sel_addr   (sel_addr),
		.o_wb_ack     (o_wb_ack),
		.o_wb_stall   (o_wb_stall),
		.o_wb_err     (o_wb_err),
		.o_wb_idata   (o_wb_idata),
		.o_err_addr   (err_addr)
	);

endmodule

//--- hdl/bus_return.sv
module bus_return (
	input  logic                i_clk,
	input  logic                i_reset,
	input  logic                i_wb_cyc,
	input  logic                i_ram_sel,
	input  logic                i_mem_ack,
	input  bus_pkg::bus_data_t  i_mem_data,
	input  logic                i_io_ack,
	input  bus_pkg::bus_data_t  i_io_data,
	input  logic                i_ram_ack,
	input  logic                i_ram_stall,
	input  bus_pkg::bus_data_t  i_ram_rdata,
	input  logic                i_ram_err,
	input  logic                i_decode_err,
	input  bus_pkg::bus_addr_t  i_sel_addr,
	output logic                o_wb_ack,
	output logic                o_wb_stall,
	output logic                o_wb_err,
	output bus_pkg::bus_data_t  o_wb_idata,
	output bus_pkg::bus_addr_t  o_err_addr
);

	// Slow group, one register behind board_io
	logic               slow_ack;
	bus_pkg::bus_data_t slow_data;

	// Fast group acks
	logic [2:0] ack_list;
	logic       many_ack;

	////////////////////////////////////////////////////////////////////////////
	// Slow group
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			slow_ack <= 1'b0;
		else
			slow_ack <= i_wb_cyc && i_io_ack;
	end

	// Only board_io lives here for now
	always_ff @(posedge i_clk)
	begin
		if (i_io_ack)
			slow_data <= i_io_data;
	end

	////////////////////////////////////////////////////////////////////////////
	// Fast group
	////////////////////////////////////////////////////////////////////////////

	assign ack_list = {i_ram_ack, i_mem_ack, slow_ack};

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_wb_ack <= 1'b0;
		else
			o_wb_ack <= i_wb_cyc && (|ack_list);
	end

	// Return data mux, RAM first
	always_ff @(posedge i_clk)
	begin
		if (i_ram_ack)
			o_wb_idata <= i_ram_rdata;
		else if (i_mem_ack)
			o_wb_idata <= i_mem_data;
		else
			o_wb_idata <= slow_data;
	end

	// Any two acks at once
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			many_ack <= 1'b0;
		else
			many_ack <= (ack_list[2] && ack_list[1])
				|| (ack_list[2] && ack_list[0])
				|| (ack_list[1] && ack_list[0]);
	end

	////////////////////////////////////////////////////////////////////////////
	// Stall, error and error address
	////////////////////////////////////////////////////////////////////////////

	// Only the external RAM pushes back; must stay combinational
	assign o_wb_stall = i_wb_cyc && i_ram_sel && i_ram_stall;

	// Decode error and many_ack are already a cycle late, RAM error is not
	assign o_wb_err = i_wb_cyc && (i_decode_err || many_ack || i_ram_err);

	// Exact for decode errors, nearby for the others
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_err_addr <= '0;
		else if (o_wb_err)
			o_err_addr <= i_sel_addr;
	end

endmodule

//--- hdl/board_io.sv
module board_io (
	input  logic                i_clk,
	input  logic                i_reset,
	input  logic                i_stb,
	input  logic                i_we,
	input  bus_pkg::bus_addr_t  i_addr,
	input  bus_pkg::bus_data_t  i_data,
	input  bus_pkg::sw_t        i_sw,
	input  bus_pkg::sw_t        i_btn,
	input  bus_pkg::bus_addr_t  i_err_addr,
	output logic                o_ack,
	output bus_pkg::bus_data_t  o_data,
	output bus_pkg::led_t       o_led
);

	bus_pkg::io_addr_t reg_idx;

	// Register index from the low address bits
	assign reg_idx = i_addr[bus_pkg::IO_AW-1:0];

	////////////////////////////////////////////////////////////////////////////
	// LED register
	////////////////////////////////////////////////////////////////////////////

	// Only the LED register is writable
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_led <= '0;
		else if (i_stb && i_we && (reg_idx == bus_pkg::IO_REG_LED))
			o_led <= i_data[bus_pkg::LED_W-1:0];
	end

	////////////////////////////////////////////////////////////////////////////
	// Read path
	////////////////////////////////////////////////////////////////////////////

	// Registered readback, LED value before any write this cycle
	always_ff @(posedge i_clk)
	begin
		if (i_stb)
		begin
			case (reg_idx)
				bus_pkg::IO_REG_INPUTS:
					// Buttons above switches
					o_data <= bus_pkg::bus_data_t'({i_btn, i_sw});
				bus_pkg::IO_REG_LED:
					o_data <= bus_pkg::bus_data_t'(o_led);
				bus_pkg::IO_REG_ERR_ADDR:
					o_data <= i_err_addr;
				default:
					// Unused indices
					o_data <= '0;
			endcase
		end
	end

	// Single-cycle ack, no stall
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_ack <= 1'b0;
		else
			o_ack <= i_stb;
	end

endmodule

//--- hdl/block_ram.sv
module block_ram (
	input  logic                i_clk,
	input  logic                i_reset,
	input  logic                i_stb,
	input  logic                i_we,
	input  bus_pkg::bus_addr_t  i_addr,
	input  bus_pkg::bus_data_t  i_data,
	output logic                o_ack,
	output bus_pkg::bus_data_t  o_data
);

	localparam int DEPTH = 1 << bus_pkg::MEM_AW;

	// Word storage
	bus_pkg::bus_data_t mem [0:DEPTH-1];

	bus_pkg::mem_addr_t word_addr;

	// Low bits index the memory, the rest was decoded upstream
	assign word_addr = i_addr[bus_pkg::MEM_AW-1:0];

	// Write on the strobe edge
	// Read registers the old word (read-first)
	always_ff @(posedge i_clk)
	begin
		if (i_stb && i_we)
			mem[word_addr] <= i_data;
		if (i_stb)
			o_data <= mem[word_addr];
	end

	// One ack per strobe, one cycle later
	// Never stalls
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_ack <= 1'b0;
		else
			o_ack <= i_stb;
	end

endmodule

//--- hdl/bus_addr_decode.sv
module bus_addr_decode (
	input  logic                i_clk,
	input  logic                i_reset,
	input  logic                i_wb_stb,
	input  bus_pkg::bus_addr_t  i_wb_addr,
	output logic                o_ram_sel,
	output logic                o_ram_stb,
	output logic                o_mem_stb,
	output logic                o_io_stb,
	output logic                o_decode_err,
	output bus_pkg::bus_addr_t  o_sel_addr
);

	logic mem_sel;
	logic io_sel;
	logic none_sel;

	////////////////////////////////////////////////////////////////////////////
	// Region selects
	////////////////////////////////////////////////////////////////////////////

	// External RAM, everything above the RAM bit must be clear
	assign o_ram_sel = i_wb_addr[bus_pkg::RAM_SEL_BIT]
		&& (i_wb_addr[bus_pkg::ADDR_W-1:bus_pkg::RAM_SEL_BIT+1] == '0);

	// Block RAM, upper bits clear (RAM bit included)
	assign mem_sel = i_wb_addr[bus_pkg::MEM_SEL_BIT]
		&& (i_wb_addr[bus_pkg::ADDR_W-1:bus_pkg::MEM_SEL_BIT+1] == '0);

	// Board I/O
	// Only the low IO_AW bits may vary below the I/O bit
	assign io_sel = i_wb_addr[bus_pkg::IO_SEL_BIT]
		&& (i_wb_addr[bus_pkg::ADDR_W-1:bus_pkg::IO_SEL_BIT+1] == '0)
		&& (i_wb_addr[bus_pkg::IO_SEL_BIT-1:bus_pkg::IO_AW] == '0);

	// Holes and stray high bits
	assign none_sel = !o_ram_sel && !mem_sel && !io_sel;

	// Strobes into each slave
	assign o_ram_stb = i_wb_stb && o_ram_sel;
	assign o_mem_stb = i_wb_stb && mem_sel;
	assign o_io_stb  = i_wb_stb && io_sel;

	////////////////////////////////////////////////////////////////////////////
	// Registered error and its address
	////////////////////////////////////////////////////////////////////////////

	// Error one cycle after the offending strobe
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_decode_err <= 1'b0;
		else
			o_decode_err <= i_wb_stb && none_sel;
	end

	// Address of the last strobe, lines up with o_decode_err
	always_ff @(posedge i_clk)
	begin
		if (i_wb_stb)
			o_sel_addr <= i_wb_addr;
	end

endmodule

//--- hdl/bus_pkg.sv
package bus_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////////////////////////////////////////

	// Word address and data width of the master bus
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// External RAM word address, as seen at the chip boundary
	localparam int RAM_AW = 26;
	// On-chip block RAM, 32k words
	localparam int MEM_AW = 15;
	// Register index inside the board I/O block
	localparam int IO_AW  = 3;

	// Board pins
	localparam int SW_W   = 4;
	localparam int LED_W  = 4;

	typedef logic [ADDR_W-1:0] bus_addr_t;
	typedef logic [DATA_W-1:0] bus_data_t;
	typedef logic [RAM_AW-1:0] ram_addr_t;
	typedef logic [MEM_AW-1:0] mem_addr_t;
	typedef logic [IO_AW-1:0]  io_addr_t;
	typedef logic [SW_W-1:0]   sw_t;
	typedef logic [LED_W-1:0]  led_t;

	////////////////////////////////////////////////////////////////////////////
	// Address map
	////////////////////////////////////////////////////////////////////////////

	// One region bit each, highest region wins
	localparam int RAM_SEL_BIT = 26;
	localparam int MEM_SEL_BIT = 15;
	localparam int IO_SEL_BIT  = 8;

	// Board I/O register indices
	// Buttons in [7:4], switches in [3:0], read only
	localparam io_addr_t IO_REG_INPUTS   = 3'd0;
	// LED register, low LED_W bits
	localparam io_addr_t IO_REG_LED      = 3'd1;
	// Last failing bus address, read only
	localparam io_addr_t IO_REG_ERR_ADDR = 3'd2;

endpackage
